// ==== mcu_io_pkg.sv ====
package mcu_io_pkg;

    // host register index, 16 slots
    typedef logic [3:0] reg_addr_t;

    // one strobe bit per host register slot
    localparam int unsigned NUM_REGS = 16;

    // host register map
    // avalon address, upper then lower half
    localparam reg_addr_t DR_AV_AD_HI       = 4'd0;
    localparam reg_addr_t DR_AV_AD_LO       = 4'd1;
    // load starts an avalon write, read strobe starts an avalon read
    localparam reg_addr_t DR_AV_WRITE_DATA  = 4'd2;
    // last captured avalon read data
    localparam reg_addr_t SR_AV_READ_DATA   = 4'd3;
    // expansion bus address and data ports
    localparam reg_addr_t DR_EXP_ADDR       = 4'd4;
    localparam reg_addr_t DR_EXP            = 4'd5;
    // timer, soft events, event controller
    localparam reg_addr_t DR_TIMER0         = 4'd6;
    localparam reg_addr_t DR_SOFT_EVENT     = 4'd7;
    localparam reg_addr_t DR_EVENT_PRIORITY = 4'd8;

    // expansion register index
    typedef logic [1:0] exp_addr_t;

    localparam exp_addr_t EDR_LEDS       = 2'd0;
    localparam exp_addr_t ESR_KEYS       = 2'd1;
    localparam exp_addr_t EDR_ANMUX_CTRL = 2'd2;

    // host side register bus, 22 bits
    typedef struct packed {
        reg_addr_t   addr;
        logic        load;
        logic        read;
        logic [15:0] load_data;
    } reg_bus_t;

    // decoded one-hot strobes toward the peripherals
    typedef struct packed {
        logic [NUM_REGS-1:0] load_sel;
        logic [NUM_REGS-1:0] read_sel;
        logic [15:0]         load_data;
    } reg_strobe_t;

    // avalon address as the mcu sees it, two 16-bit halves
    typedef struct packed {
        logic [15:0] hi;
        logic [15:0] lo;
    } av_addr_halves_t;

    // same address as the bus sees it
    typedef union packed {
        av_addr_halves_t half;
        logic [31:0]     word;
    } av_addr_u;

    // avalon master request side, 50 bits
    typedef struct packed {
        av_addr_u    address;
        logic        read;
        logic        write;
        logic [15:0] writedata;
    } av_req_t;

    // bridge words in map order: hi, lo, write data, read data
    typedef logic [3:0][15:0] av_words_t;

    // default widths
    localparam int NUM_EVENTS_DEFAULT    = 16;
    localparam int PRESCALE_BITS_DEFAULT = 16;

endpackage

// ==== reg_decoder.sv ====
`timescale 1ns/1ns

module reg_decoder (
    input  logic                    sysclk,
    input  logic                    sysreset,
    input  mcu_io_pkg::reg_bus_t    host_bus,
    output mcu_io_pkg::reg_strobe_t strobes,
    input  mcu_io_pkg::av_words_t   av_words,
    input  logic [15:0]             exp_word,
    input  logic [15:0]             timer_word,
    input  logic [15:0]             soft_word,
    input  logic [15:0]             priority_word,
    output logic [15:0]             rd_data
);

    // one-hot slot for the current address
    logic [mcu_io_pkg::NUM_REGS-1:0] addr_onehot;

    always_comb begin
        addr_onehot = '0;
        addr_onehot[host_bus.addr] = 1'b1;
    end

    // strobes only fire when the host qualifies them
    always_comb begin
        strobes.load_sel  = host_bus.load ? addr_onehot : '0;
        strobes.read_sel  = host_bus.read ? addr_onehot : '0;
        strobes.load_data = host_bus.load_data;
    end

    // read mux, purely combinational from the address
    always_comb begin
        case (host_bus.addr)
            mcu_io_pkg::DR_AV_AD_HI: begin
                rd_data = av_words[0];
            end
            mcu_io_pkg::DR_AV_AD_LO: begin
                rd_data = av_words[1];
            end
            mcu_io_pkg::DR_AV_WRITE_DATA: begin
                rd_data = av_words[2];
            end
            mcu_io_pkg::SR_AV_READ_DATA: begin
                rd_data = av_words[3];
            end
            // expander picks address or data view itself
            mcu_io_pkg::DR_EXP_ADDR,
            mcu_io_pkg::DR_EXP: begin
                rd_data = exp_word;
            end
            mcu_io_pkg::DR_TIMER0: begin
                rd_data = timer_word;
            end
            mcu_io_pkg::DR_SOFT_EVENT: begin
                rd_data = soft_word;
            end
            mcu_io_pkg::DR_EVENT_PRIORITY: begin
                rd_data = priority_word;
            end
            // unmapped slots
            default: begin
                rd_data = '0;
            end
        endcase
    end

    // peripherals rely on at most one register being touched per cycle
    a_strobe_onehot: assert property (@(posedge sysclk) disable iff (sysreset)
        $onehot0({strobes.load_sel, strobes.read_sel}))
        else $error("reg_decoder: load and read strobes fired together");

endmodule

// ==== av_master_bridge.sv ====
`timescale 1ns/1ns

module av_master_bridge (
    input  logic                    sysclk,
    input  logic                    sysreset,
    input  mcu_io_pkg::reg_strobe_t strobes,
    output mcu_io_pkg::av_words_t   av_words,
    output mcu_io_pkg::av_req_t     av_req,
    input  logic                    av_waitrequest,
    input  logic [15:0]             av_readdata,
    output logic                    mcu_wait
);

    // address loaded by halves, driven as one word
    mcu_io_pkg::av_addr_u av_addr;
    logic [15:0]          wr_data;
    logic [15:0]          rd_data;
    // readdata sampled on the ending cycle of a read
    logic [15:0]          rd_stage;
    logic                 av_write;
    logic                 av_read;
    // one cycle after the read ends, moves rd_stage into rd_data
    logic                 capture_q;
    logic                 write_end;
    logic                 read_end;

    // transfer ends when the strobe is up and the slave lets go
    assign write_end = av_write && !av_waitrequest;
    assign read_end  = av_read && !av_waitrequest;

    // host side registers
    always_ff @(posedge sysclk or posedge sysreset) begin
        if (sysreset) begin
            av_addr <= '0;
            wr_data <= '0;
        end else begin
            if (strobes.load_sel[mcu_io_pkg::DR_AV_AD_HI]) begin
                av_addr.half.hi <= strobes.load_data;
            end
            if (strobes.load_sel[mcu_io_pkg::DR_AV_AD_LO]) begin
                av_addr.half.lo <= strobes.load_data;
            end
            if (strobes.load_sel[mcu_io_pkg::DR_AV_WRITE_DATA]) begin
                wr_data <= strobes.load_data;
            end
        end
    end

    // one transfer at a time
    // order: end of write, start of write, end of read, start of read
    always_ff @(posedge sysclk or posedge sysreset) begin
        if (sysreset) begin
            av_write <= 1'b0;
            av_read  <= 1'b0;
        end else if (write_end) begin
            av_write <= 1'b0;
        end else if (strobes.load_sel[mcu_io_pkg::DR_AV_WRITE_DATA]) begin
            av_write <= 1'b1;
        end else if (read_end) begin
            // data lands in SR_AV_READ_DATA two edges from now
            av_read <= 1'b0;
        end else if (strobes.read_sel[mcu_io_pkg::DR_AV_WRITE_DATA]) begin
            av_read <= 1'b1;
        end
    end

    // read data path, stage then capture
    always_ff @(posedge sysclk or posedge sysreset) begin
        if (sysreset) begin
            capture_q <= 1'b0;
            rd_stage  <= '0;
            rd_data   <= '0;
        end else begin
            capture_q <= read_end;
            if (read_end) begin
                rd_stage <= av_readdata;
            end
            if (capture_q) begin
                rd_data <= rd_stage;
            end
        end
    end

    // mcu stalls through the whole transfer and the capture cycle
    assign mcu_wait = av_write || av_read || capture_q;

    always_comb begin
        av_req.address.word = av_addr.word;
        av_req.read         = av_read;
        av_req.write        = av_write;
        av_req.writedata    = wr_data;
    end

    // words back to the decoder, map order
    assign av_words[0] = av_addr.half.hi;
    assign av_words[1] = av_addr.half.lo;
    assign av_words[2] = wr_data;
    assign av_words[3] = rd_data;

    // host must honour the stall
    a_no_strobe_busy: assert property (@(posedge sysclk) disable iff (sysreset)
        mcu_wait |-> (strobes.load_sel == '0) && (strobes.read_sel == '0))
        else $error("av_master_bridge: host strobe while mcu_wait high");

    a_rd_wr_excl: assert property (@(posedge sysclk) disable iff (sysreset)
        !(av_req.read && av_req.write))
        else $error("av_master_bridge: avalon read and write both high");

endmodule

// ==== bus_expander.sv ====
`timescale 1ns/1ns

module bus_expander (
    input  logic                    sysclk,
    input  logic                    sysreset,
    input  mcu_io_pkg::reg_strobe_t strobes,
    input  logic [1:0]              keys,
    output logic [15:0]             exp_word,
    output logic [7:0]              leds,
    output logic [3:0]              anmux_ctrl
);

    // expansion register pointer
    mcu_io_pkg::exp_addr_t exp_addr;
    logic [7:0]            led_q;
    // dg408 en, a2, a1, a0
    logic [3:0]            anmux_q;
    // addressed expansion register, zero-extended
    logic [15:0]           exp_rd;

    always_ff @(posedge sysclk or posedge sysreset) begin
        if (sysreset) begin
            exp_addr <= '0;
        end else if (strobes.load_sel[mcu_io_pkg::DR_EXP_ADDR]) begin
            exp_addr <= strobes.load_data[1:0];
        end
    end

    // DR_EXP loads go to whichever register the pointer names
    always_ff @(posedge sysclk or posedge sysreset) begin
        if (sysreset) begin
            led_q   <= '0;
            anmux_q <= '0;
        end else if (strobes.load_sel[mcu_io_pkg::DR_EXP]) begin
            case (exp_addr)
                mcu_io_pkg::EDR_LEDS: begin
                    led_q <= strobes.load_data[7:0];
                end
                mcu_io_pkg::EDR_ANMUX_CTRL: begin
                    anmux_q <= strobes.load_data[3:0];
                end
                // keys are status only, slot 3 is empty
                default: begin
                end
            endcase
        end
    end

    // expansion read mux
    always_comb begin
        case (exp_addr)
            mcu_io_pkg::EDR_LEDS: begin
                exp_rd = {8'h00, led_q};
            end
            mcu_io_pkg::ESR_KEYS: begin
                // raw pins, pressed reads 0
                exp_rd = {14'h0000, keys};
            end
            mcu_io_pkg::EDR_ANMUX_CTRL: begin
                exp_rd = {12'h000, anmux_q};
            end
            default: begin
                exp_rd = '0;
            end
        endcase
    end

    // a read strobe on DR_EXP_ADDR returns the pointer itself
    assign exp_word = strobes.read_sel[mcu_io_pkg::DR_EXP_ADDR]
                    ? {14'h0000, exp_addr}
                    : exp_rd;

    assign leds       = led_q;
    assign anmux_ctrl = anmux_q;

endmodule

// ==== event_timer.sv ====
`timescale 1ns/1ns

module event_timer #(
    parameter int PRESCALE_BITS = 16,
    // at most 16, one per event bit
    parameter int NUM_EVENTS    = 16
) (
    input  logic                    sysclk,
    input  logic                    sysreset,
    input  mcu_io_pkg::reg_strobe_t strobes,
    output logic [15:0]             timer_word,
    output logic [15:0]             priority_word
    ,
    output logic [15:0]             soft_word
);

    localparam int COUNT_BITS = 16 + PRESCALE_BITS;

    // prescale bits sit below the visible 16
    logic [COUNT_BITS-1:0] timer0;
    logic                  timer0_done;
    logic                  timer0_load;
    logic [15:0]           soft_event;
    logic [15:0]           event_mask;
    logic [15:0]           event_vec;
    logic [NUM_EVENTS-1:0] pending;

    assign timer0_load = strobes.load_sel[mcu_io_pkg::DR_TIMER0];
    assign timer0_done = (timer0 == '0);

    // countdown, parks at zero
    always_ff @(posedge sysclk or posedge sysreset) begin
        if (sysreset) begin
            timer0 <= '0;
        end else if (timer0_load) begin
            timer0 <= {strobes.load_data, {PRESCALE_BITS{1'b0}}};
        end else if (!timer0_done) begin
            timer0 <= timer0 - 1'b1;
        end
    end

    assign timer_word = timer0[COUNT_BITS-1 -: 16];

    // soft events and the enable mask
    always_ff @(posedge sysclk or posedge sysreset) begin
        if (sysreset) begin
            soft_event <= '0;
            event_mask <= '0;
        end else begin
            if (strobes.load_sel[mcu_io_pkg::DR_SOFT_EVENT]) begin
                soft_event <= strobes.load_data;
            end
            if (strobes.load_sel[mcu_io_pkg::DR_EVENT_PRIORITY]) begin
                event_mask <= strobes.load_data;
            end
        end
    end

    assign soft_word = soft_event;

    // bit 0 is the timer, soft bit 0 is shadowed by it
    assign event_vec = {soft_event[15:1], timer0_done};
    assign pending   = event_vec[NUM_EVENTS-1:0] & event_mask[NUM_EVENTS-1:0];

    // lowest index wins, NUM_EVENTS when idle
    always_comb begin
        priority_word = 16'(NUM_EVENTS);
        for (int i = NUM_EVENTS - 1; i >= 0; i--) begin
            if (pending[i]) begin
                priority_word = 16'(i);
            end
        end
    end

    // only a host load may move the count upward
    a_timer_monotonic: assert property (@(posedge sysclk) disable iff (sysreset)
        !timer0_load |=> (timer0 <= $past(timer0)))
        else $error("event_timer: timer0 increased without a load");

endmodule

// ==== mcu_io_top.sv ====
`timescale 1ns/1ns

module mcu_io_top #(
    parameter int PRESCALE_BITS = mcu_io_pkg::PRESCALE_BITS_DEFAULT,
    parameter int NUM_EVENTS    = mcu_io_pkg::NUM_EVENTS_DEFAULT
) (
    input  logic                 sysclk,
    input  logic                 sysreset,
    input  mcu_io_pkg::reg_bus_t host_bus,
    output logic [15:0]          rd_data,
    output logic                 mcu_wait,
    output mcu_io_pkg::av_req_t  av_req,
    input  logic                 av_waitrequest,
    input  logic [15:0]          av_readdata,
    input  logic [1:0]           keys,
    output logic [7:0]           leds,
    output logic [3:0]           anmux_ctrl
);

    mcu_io_pkg::reg_strobe_t strobes;
    mcu_io_pkg::av_words_t   av_words;
    logic [15:0]             exp_word;
    logic [15:0]             timer_word;
    logic [15:0]             soft_word;
    logic [15:0]             priority_word;

    // host bus decode and read mux
    reg_decoder i_reg_decoder (
        .sysclk        (sysclk),
        .sysreset      (sysreset),
        .host_bus      (host_bus),
        .strobes       (strobes),
        .av_words      (av_words),
        .exp_word      (exp_word),
        .timer_word    (timer_word),
        .soft_word     (soft_word),
        .priority_word (priority_word),
        .rd_data       (rd_data)
    );

    // avalon master, stalls the mcu
    av_master_bridge i_av_master_bridge (
        .sysclk         (sysclk),
        .sysreset       (sysreset),
        .strobes        (strobes),
        .av_words       (av_words),
        .av_req         (av_req),
        .av_waitrequest (av_waitrequest),
        .av_readdata    (av_readdata),
        .mcu_wait       (mcu_wait)
    );

    // leds, keys, analog mux
    bus_expander i_bus_expander (
        .sysclk     (sysclk),
        .sysreset   (sysreset),
        .strobes    (strobes),
        .keys       (keys),
        .exp_word   (exp_word),
        .leds       (leds),
        .anmux_ctrl (anmux_ctrl)
    );

    event_timer #(
        .PRESCALE_BITS (PRESCALE_BITS),
        .NUM_EVENTS    (NUM_EVENTS)
    ) i_event_timer (
        .sysclk        (sysclk),
        .sysreset      (sysreset),
        .strobes       (strobes),
        .timer_word    (timer_word),
        .priority_word (priority_word),
        .soft_word     (soft_word)
    );

endmodule

// ==== tb_av_slave_model.sv ====
`timescale 1ns/1ns

module tb_av_slave_model (
    input  logic                sysclk,
    input  logic                sysreset,
    input  mcu_io_pkg::av_req_t av_req,
    // address the host last set up, tracked by the testbench
    input  logic [31:0]         expected_addr,
    output logic                av_waitrequest,
    output logic [15:0]         av_readdata,
    output logic                addr_err
);

    // 256 words, indexed by the low address byte
    logic [15:0] mem [0:255];
    logic        active;
    int unsigned stall;

    initial begin
        // fill depends on every index bit
        for (int i = 0; i < 256; i++) begin
            mem[i] = {~8'(i), 8'(i)};
        end
        av_waitrequest = 1'b1;
        av_readdata    = '0;
        addr_err       = 1'b0;
        active         = 1'b0;
        stall          = 0;
        // fixed seed for the stall pattern
        void'($urandom(32'ha22d));

        // slave outputs move a little after the edge
        forever begin
            @(posedge sysclk);
            #5;
            if (sysreset || !(av_req.read || av_req.write)) begin
                av_waitrequest = 1'b1;
                active         = 1'b0;
            end else begin
                if (!active) begin
                    // new transfer, pick 0 to 3 stall cycles
                    active = 1'b1;
                    stall  = $urandom % 4;
                    if (av_req.address.word !== expected_addr) begin
                        $display("ERR av_req.address: got 0x%h expected 0x%h",
                                 av_req.address.word, expected_addr);
                        addr_err = 1'b1;
                    end
                end
                if (stall == 0) begin
                    // last cycle of the transfer
                    av_waitrequest = 1'b0;
                    if (av_req.write) begin
                        mem[av_req.address.word[7:0]] = av_req.writedata;
                    end else begin
                        av_readdata = mem[av_req.address.word[7:0]];
                    end
                    active = 1'b0;
                end else begin
                    av_waitrequest = 1'b1;
                    stall--;
                end
            end
        end
    end

endmodule

// ==== tb_mcu_io.sv ====
`timescale 1ns/1ns

module tb_mcu_io;

    localparam int PRESCALE_BITS = 4;
    // clocks allowed for any single wait or poll
    localparam int TIMEOUT       = 2000;

    logic                 sysclk;
    logic                 sysreset;
    mcu_io_pkg::reg_bus_t host_bus;
    logic [15:0]          rd_data;
    logic                 mcu_wait;
    mcu_io_pkg::av_req_t  av_req;
    logic                 av_waitrequest;
    logic [15:0]          av_readdata;
    logic [1:0]           keys;
    logic [7:0]           leds;
    logic [3:0]           anmux_ctrl;
    logic                 addr_err;

    // expected state, built from the loads in the vectors
    logic [31:0]          exp_av_addr;
    logic [1:0]           exp_idx;
    logic [7:0]           exp_leds;
    logic [3:0]           exp_anmux;

    mcu_io_top #(
        .PRESCALE_BITS (PRESCALE_BITS)
    ) i_dut (
        .sysclk         (sysclk),
        .sysreset       (sysreset),
        .host_bus       (host_bus),
        .rd_data        (rd_data),
        .mcu_wait       (mcu_wait),
        .av_req         (av_req),
        .av_waitrequest (av_waitrequest),
        .av_readdata    (av_readdata),
        .keys           (keys),
        .leds           (leds),
        .anmux_ctrl     (anmux_ctrl)
    );

    tb_av_slave_model i_av_slave (
        .sysclk         (sysclk),
        .sysreset       (sysreset),
        .av_req         (av_req),
        .expected_addr  (exp_av_addr),
        .av_waitrequest (av_waitrequest),
        .av_readdata    (av_readdata),
        .addr_err       (addr_err)
    );

    // 100 ns period
    initial sysclk = 1'b0;
    always #50 sysclk = ~sysclk;

    task automatic stop_with_failure();
        $display("FAIL: see errors above");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_value(input string name, input logic [15:0] got,
                               input logic [15:0] expected);
        assert (got === expected) else begin
            $display("ERR %s: got 0x%h expected 0x%h", name, got, expected);
            stop_with_failure();
        end
    endtask

    task automatic drive_bus(input logic [3:0] addr, input logic load, input logic read,
                             input logic [15:0] data);
        host_bus.addr      = addr;
        host_bus.load      = load;
        host_bus.read      = read;
        host_bus.load_data = data;
    endtask

    // host may only strobe once the bridge has let go
    task automatic wait_ready();
        int n;
        n = 0;
        while (mcu_wait && n < TIMEOUT) begin
            @(posedge sysclk);
            #5;
            n++;
        end
        if (mcu_wait) begin
            $display("timeout: mcu_wait still high after %0d clocks", TIMEOUT);
            stop_with_failure();
        end
        assert (!addr_err) else begin
            $display("avalon slave was addressed at a location the host never set up");
            stop_with_failure();
        end
    endtask

    task automatic load_reg(input logic [3:0] addr, input logic [15:0] data);
        wait_ready();
        drive_bus(addr, 1'b1, 1'b0, data);
        @(posedge sysclk);
        #5;
        drive_bus(4'h0, 1'b0, 1'b0, 16'h0000);
    endtask

    // read strobe plus a sample in the middle of the cycle
    task automatic read_reg(input logic [3:0] addr, output logic [15:0] data);
        wait_ready();
        drive_bus(addr, 1'b0, 1'b1, 16'h0000);
        @(negedge sysclk);
        data = rd_data;
        @(posedge sysclk);
        #5;
        drive_bus(4'h0, 1'b0, 1'b0, 16'h0000);
    endtask

    task automatic poll_reg(input logic [3:0] addr, input logic [15:0] value);
        logic [15:0] got;
        int          n;
        n = 0;
        read_reg(addr, got);
        while (got !== value && n < TIMEOUT) begin
            read_reg(addr, got);
            n++;
        end
        if (got !== value) begin
            $display("timeout: register 0x%h read 0x%h and never reached 0x%h",
                     addr, got, value);
            stop_with_failure();
        end
    endtask

    // what a load should do to the visible state
    task automatic track_load(input logic [3:0] addr, input logic [15:0] data);
        case (addr)
            mcu_io_pkg::DR_AV_AD_HI: begin
                exp_av_addr[31:16] = data;
            end
            mcu_io_pkg::DR_AV_AD_LO: begin
                exp_av_addr[15:0] = data;
            end
            mcu_io_pkg::DR_EXP_ADDR: begin
                exp_idx = data[1:0];
            end
            mcu_io_pkg::DR_EXP: begin
                if (exp_idx == mcu_io_pkg::EDR_LEDS) begin
                    exp_leds = data[7:0];
                end else if (exp_idx == mcu_io_pkg::EDR_ANMUX_CTRL) begin
                    exp_anmux = data[3:0];
                end
            end
            default: begin
            end
        endcase
    endtask

    task automatic run_op(input logic [63:0] op, input logic [15:0] addr,
                          input logic [15:0] data);
        logic [15:0] got;
        case (op)
            "W": begin
                track_load(addr[3:0], data);
                load_reg(addr[3:0], data);
            end
            "R": begin
                read_reg(addr[3:0], got);
                assert (got === data) else begin
                    $display("ERR rd_data at 0x%h: got 0x%h expected 0x%h",
                             addr[3:0], got, data);
                    stop_with_failure();
                end
            end
            "S": begin
                read_reg(addr[3:0], got);
            end
            "P": begin
                poll_reg(addr[3:0], data);
            end
            "K": begin
                keys = data[1:0];
            end
            default: begin
                $display("unknown operation in the vectors file");
                stop_with_failure();
            end
        endcase
        // expansion outputs follow the loads
        check_value("leds", 16'(leds), 16'(exp_leds));
        check_value("anmux_ctrl", 16'(anmux_ctrl), 16'(exp_anmux));
    endtask

    initial begin
        int              fd;
        int              code;
        logic [63:0]     tok;
        logic [15:0]     op_addr;
        logic [15:0]     op_data;
        logic [8*80-1:0] rest;

        sysreset    = 1'b1;
        host_bus    = '0;
        // no key pressed
        keys        = 2'b11;
        exp_av_addr = '0;
        exp_idx     = '0;
        exp_leds    = '0;
        exp_anmux   = '0;
        repeat (5) @(posedge sysclk);
        #5;
        sysreset = 1'b0;

        // pins the register reads cannot see
        assert (!mcu_wait && !av_req.read && !av_req.write) else begin
            $display("ERR mcu_wait/av_req.read/av_req.write: got %h/%h/%h expected 0/0/0",
                     mcu_wait, av_req.read, av_req.write);
            stop_with_failure();
        end
        check_value("leds", 16'(leds), 16'h0000);
        check_value("anmux_ctrl", 16'(anmux_ctrl), 16'h0000);

        fd = $fopen("mcu_io_vectors.txt", "r");
        if (fd == 0) begin
            $display("cannot open mcu_io_vectors.txt");
            stop_with_failure();
        end
        while (!$feof(fd)) begin
            code = $fscanf(fd, "%s", tok);
            if (code != 1) begin
                break;
            end
            if (tok == "#") begin
                // comment line
                code = $fgets(rest, fd);
            end else begin
                code = $fscanf(fd, "%h %h", op_addr, op_data);
                if (code != 2) begin
                    $display("malformed line in the vectors file");
                    stop_with_failure();
                end
                run_op(tok, op_addr, op_data);
            end
        end
        $fclose(fd);

        // last transfer settled
        wait_ready();
        $display("PASS: all tests");
        $finish;
    end

endmodule

// ==== mcu_io_vectors.txt ====
# op addr data, all hex; W load, R read and compare, S read strobe only
# P poll until the register reads data, K drive keys from data
# reset state
R 0 0000
R 1 0000
R 3 0000
R 4 0000
R 5 0000
R 6 0000
R 7 0000
R 8 0010
R f 0000
R 2 0000
# avalon writes
W 0 0012
W 1 0034
W 2 beef
W 1 0035
W 2 1234
W 2 5a5a
W 0 0013
W 1 00a0
W 2 cafe
# avalon reads back
W 0 0012
W 1 0034
S 2 0000
R 3 beef
W 1 0035
S 2 0000
R 3 5a5a
W 0 0013
W 1 00a0
S 2 0000
R 3 cafe
R 1 00a0
# expansion bus
W 4 0000
W 5 00a5
R 5 00a5
W 4 0002
W 5 0009
R 5 0009
R 4 0002
K 0 0002
W 4 0001
R 5 0002
R 4 0001
W 5 00ff
# event priority and timer
W 8 fffe
W 7 00a8
R 7 00a8
R 8 0003
W 8 fff0
R 8 0005
W 7 0000
R 8 0010
W 6 0010
W 8 0001
R 8 0010
P 6 0000
P 8 0000

// ==== mcu_io.f ====
mcu_io_pkg.sv
reg_decoder.sv
av_master_bridge.sv
bus_expander.sv
event_timer.sv
mcu_io_top.sv
tb_av_slave_model.sv
tb_mcu_io.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_mcu_io
FILELIST  ?= mcu_io.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= PASS: all tests
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: sim clean

# build, run, then look for the pass line in the log
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
